// ==== filelist.f ====
+incdir+common
common/gbc_io_pkg.sv
timer/timer_unit.sv
source/misc_register_bank.sv
source/io_read_return.sv
source/gbc_io_subsystem.sv
verif/gbc_io_clock_gen.sv
verif/gbc_io_assert.sv
verif/gbc_io_tb.sv

// ==== Makefile ====
TOP := gbc_io_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f filelist.f --top-module gbc_io_subsystem
	verilator --lint-only --timing -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; echo "simulator exit status $$?" >> sim.log
	cat sim.log
	@if grep -q -e "RESULT: FAIL" -e "%Error" sim.log || ! grep -q "RESULT: PASS" sim.log; then \
		echo "Simulation failed, see sim.log"; \
		exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir sim.log

// ==== verif/gbc_io_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gbc_io_settings.svh"

module gbc_io_tb;

   localparam int clock_period_ns  = 4;
   // Longest waits are 768 cycles (DIV) and 2000 cycles (timer off)
   localparam int budget_cycles    = 50_000;
   localparam int div_wait_periods = 3;

   // Bank registers with their specified reset values and write masks
   localparam logic [15:0] bank_addr [10] = '{
      `GBC_IO_ADDR_SB,   `GBC_IO_ADDR_SC,   `GBC_IO_ADDR_KEY1, `GBC_IO_ADDR_FF6C,
      `GBC_IO_ADDR_FF72, `GBC_IO_ADDR_FF73, `GBC_IO_ADDR_FF74, `GBC_IO_ADDR_FF75,
      `GBC_IO_ADDR_FF76, `GBC_IO_ADDR_FF77
   };
   localparam logic [7:0] bank_reset [10] = '{
      8'h00, 8'h7C, 8'hFD, 8'hFE, 8'h00, 8'h00, 8'h00, 8'h8F, 8'h00, 8'h00
   };
   localparam logic [7:0] bank_mask [10] = '{
      8'hFF, 8'hFF, 8'h01, 8'h01, 8'hFF, 8'hFF, 8'hFF, 8'h70, 8'h00, 8'h00
   };
   localparam logic [15:0] unmapped_addr = 16'hFF50;

   logic                    clock_main;
   logic                    synch_reset;
   gbc_io_pkg::io_bus_req_t bus;
   logic [7:0]              rdata;
   logic                    rdata_valid;
   logic                    timer_irq;

   logic [7:0] bank_model [10];
   integer     seed;
   int         error_count;
   int         check_count;
   int         irq_pulses;
   logic       irq_prev;

   gbc_io_clock_gen #(.period_ns(clock_period_ns), .reset_cycles(2)) i_clock_gen (
      .clock_main  (clock_main),
      .synch_reset (synch_reset)
   );

   gbc_io_subsystem i_dut (
      .clock_main  (clock_main),
      .synch_reset (synch_reset),
      .bus         (bus),
      .rdata       (rdata),
      .rdata_valid (rdata_valid),
      .timer_irq   (timer_irq)
   );

   // Rising edges of timer_irq
   always @(negedge clock_main) begin
      if (timer_irq && !irq_prev) begin
         irq_pulses = irq_pulses + 1;
      end
      irq_prev = timer_irq;
   end

   // ==========================================================================
   // Compare tasks
   // ==========================================================================

   task automatic check_byte(input string what, input logic [7:0] actual,
                             input logic [7:0] expected);
      check_count++;
      if (actual !== expected) begin
         error_count++;
         $display("[FAIL] t=%0t rdata (%s): expected %02h, got %02h",
                  $time, what, expected, actual);
      end
   endtask

   task automatic check_byte_either(input string what, input logic [7:0] actual,
                                    input logic [7:0] option_a, input logic [7:0] option_b);
      check_count++;
      if (actual !== option_a && actual !== option_b) begin
         error_count++;
         $display("[FAIL] t=%0t rdata (%s): expected %02h or %02h, got %02h",
                  $time, what, option_a, option_b, actual);
      end
   endtask

   task automatic check_flag(input string name, input logic actual, input logic expected);
      check_count++;
      if (actual !== expected) begin
         error_count++;
         $display("[FAIL] t=%0t %s: expected %0b, got %0b", $time, name, expected, actual);
      end
   endtask

   task automatic check_irq(input int expected);
      check_count++;
      if (irq_pulses != expected) begin
         error_count++;
         $display("[FAIL] t=%0t timer_irq pulses: expected %0d, got %0d",
                  $time, expected, irq_pulses);
      end
   endtask

   // ==========================================================================
   // Bus access
   // ==========================================================================

   task automatic drive_read(input logic [15:0] addr);
      bus <= '{addr: addr, wdata: 8'h00, we_l: 1'b1, re_l: 1'b0};
   endtask

   task automatic write_reg(input logic [15:0] addr, input logic [7:0] data);
      @(posedge clock_main);
      bus <= '{addr: addr, wdata: data, we_l: 1'b0, re_l: 1'b1};
      @(posedge clock_main);
      bus <= gbc_io_pkg::bus_idle;
   endtask

   // Data is sampled mid-cycle after the edge that takes the request
   task automatic read_reg(input logic [15:0] addr, output logic [7:0] value);
      @(posedge clock_main);
      drive_read(addr);
      @(posedge clock_main);
      bus <= gbc_io_pkg::bus_idle;
      @(negedge clock_main);
      check_flag("rdata_valid", rdata_valid, 1'b1);
      value = rdata;
   endtask

   task automatic read_expect(input logic [15:0] addr, input logic [7:0] expected,
                              input string what);
      logic [7:0] value;
      read_reg(addr, value);
      check_byte(what, value, expected);
   endtask

   // ==========================================================================
   // Directed tests
   // ==========================================================================

   task automatic test_reset_values();
      @(negedge clock_main);
      check_flag("rdata_valid", rdata_valid, 1'b0);
      check_flag("timer_irq", timer_irq, 1'b0);
      read_expect(`GBC_IO_ADDR_DIV, 8'h00, "DIV after reset");
      read_expect(`GBC_IO_ADDR_TIMA, 8'h00, "TIMA after reset");
      read_expect(`GBC_IO_ADDR_TMA, 8'h00, "TMA after reset");
      read_expect(`GBC_IO_ADDR_TAC, 8'h00, "TAC after reset");
      for (int i = 0; i < 10; i++) begin
         read_expect(bank_addr[i], bank_reset[i], "bank reset value");
      end
      read_expect(unmapped_addr, 8'hFF, "unmapped FF50");
   endtask

   task automatic test_write_masks();
      logic [7:0] data;
      for (int round = 0; round < 2; round++) begin
         for (int i = 0; i < 10; i++) begin
            data = 8'($random(seed));
            write_reg(bank_addr[i], data);
            bank_model[i] = (bank_model[i] & ~bank_mask[i]) | (data & bank_mask[i]);
            read_expect(bank_addr[i], bank_model[i], "masked write");
         end
      end
      read_expect(`GBC_IO_ADDR_FF76, 8'h00, "read-only FF76");
      read_expect(`GBC_IO_ADDR_FF77, 8'h00, "read-only FF77");
   endtask

   task automatic test_div();
      logic [7:0] value;
      write_reg(`GBC_IO_ADDR_DIV, 8'($random(seed)));
      // DIV steps once every 256 clocks
      repeat (div_wait_periods * 256) @(posedge clock_main);
      read_reg(`GBC_IO_ADDR_DIV, value);
      check_byte_either("DIV after wait", value, 8'(div_wait_periods),
                        8'(div_wait_periods - 1));
      write_reg(`GBC_IO_ADDR_DIV, 8'h5A);
      read_expect(`GBC_IO_ADDR_DIV, 8'h00, "DIV after clear");
   endtask

   task automatic test_timer_overflow();
      logic [7:0] value;
      irq_pulses = 0;
      write_reg(`GBC_IO_ADDR_DIV, 8'h00);
      write_reg(`GBC_IO_ADDR_TMA, 8'hF0);
      write_reg(`GBC_IO_ADDR_TIMA, 8'hFE);
      write_reg(`GBC_IO_ADDR_TAC, 8'h05);
      repeat (40) @(posedge clock_main);
      check_irq(1);
      read_reg(`GBC_IO_ADDR_TIMA, value);
      check_byte_either("TIMA after overflow", value, 8'hF0, 8'hF1);
   endtask

   task automatic test_timer_disabled();
      logic [7:0] tac_value;
      logic [7:0] tima_value;
      // Enable bit clear, other bits random
      tac_value = 8'($random(seed)) & 8'hFB;
      tima_value = 8'($random(seed));
      write_reg(`GBC_IO_ADDR_TAC, tac_value);
      write_reg(`GBC_IO_ADDR_TIMA, tima_value);
      irq_pulses = 0;
      repeat (2000) @(posedge clock_main);
      check_irq(0);
      read_expect(`GBC_IO_ADDR_TIMA, tima_value, "TIMA with timer off");
      read_expect(`GBC_IO_ADDR_TAC, tac_value, "TAC readback");
   endtask

   task automatic test_back_to_back();
      logic [15:0] addrs [3];
      logic [7:0]  want [3];
      logic [7:0]  tma_value;
      tma_value = 8'($random(seed));
      write_reg(`GBC_IO_ADDR_TMA, tma_value);
      // KEY1 last, its upper bits are fixed so it never reads as open bus
      addrs = '{`GBC_IO_ADDR_TMA, unmapped_addr, bank_addr[2]};
      want = '{tma_value, 8'hFF, bank_model[2]};
      for (int i = 0; i <= 3; i++) begin
         @(posedge clock_main);
         if (i < 3) begin
            drive_read(addrs[i]);
         end else begin
            bus <= gbc_io_pkg::bus_idle;
         end
         if (i > 0) begin
            @(negedge clock_main);
            check_flag("rdata_valid", rdata_valid, 1'b1);
            check_byte("back-to-back read", rdata, want[i - 1]);
         end
      end
      // Idle cycle, last data holds
      @(negedge clock_main);
      check_flag("rdata_valid", rdata_valid, 1'b0);
      check_byte("held data", rdata, want[2]);
   endtask

   // ==========================================================================
   // Sequence and watchdog
   // ==========================================================================

   initial begin
      bus = gbc_io_pkg::bus_idle;
      seed = 32'hed6b;
      error_count = 0;
      check_count = 0;
      irq_pulses = 0;
      irq_prev = 1'b0;
      for (int i = 0; i < 10; i++) begin
         bank_model[i] = bank_reset[i];
      end
      @(posedge clock_main);
      while (synch_reset) begin
         @(posedge clock_main);
      end
      test_reset_values();
      test_write_masks();
      test_div();
      test_timer_overflow();
      test_timer_disabled();
      test_back_to_back();
      $display("Checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

   initial begin
      #(budget_cycles * clock_period_ns);
      $display("Timeout: tests still running after %0d ns", budget_cycles * clock_period_ns);
      $display("RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verif/gbc_io_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module gbc_io_assert (
   input wire logic                    clock_main,
   input wire logic                    synch_reset,
   input wire gbc_io_pkg::io_bus_req_t bus,
   input wire gbc_io_pkg::io_reply_t   timer_reply,
   input wire gbc_io_pkg::io_reply_t   bank_reply,
   input wire logic                    rdata_valid,
   input wire logic                    timer_irq
);

   logic read_req;

   assign read_req = (bus.re_l == gbc_io_pkg::strobe_active);

   // Address ranges of the two blocks are disjoint
   replies_exclusive: assert property (@(posedge clock_main) disable iff (synch_reset)
      !(timer_reply.hit && bank_reply.hit))
      else $error("Timer and bank both answer address %04h", bus.addr);

   // Valid exactly in the cycle after a request
   valid_follows_read: assert property (@(posedge clock_main) disable iff (synch_reset)
      rdata_valid == $past(read_req))
      else $error("rdata_valid does not follow the read request of the previous cycle");

   irq_single_cycle: assert property (@(posedge clock_main) disable iff (synch_reset)
      timer_irq |=> !timer_irq)
      else $error("timer_irq held high for more than one cycle");

endmodule

bind gbc_io_subsystem gbc_io_assert i_assert (
   .clock_main  (clock_main),
   .synch_reset (synch_reset),
   .bus         (bus),
   .timer_reply (timer_reply),
   .bank_reply  (bank_reply),
   .rdata_valid (rdata_valid),
   .timer_irq   (timer_irq)
);

`default_nettype wire

// ==== verif/gbc_io_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module gbc_io_clock_gen #(
   parameter int period_ns    = 4,
   parameter int reset_cycles = 2
) (
   output logic clock_main,
   output logic synch_reset
);

   initial begin
      clock_main = 1'b0;
      forever begin
         #(period_ns / 2);
         clock_main = ~clock_main;
      end
   end

   // Reset released on a rising edge, like any other synchronous input
   initial begin
      synch_reset = 1'b1;
      repeat (reset_cycles) @(posedge clock_main);
      synch_reset <= 1'b0;
   end

endmodule

`default_nettype wire

// ==== source/gbc_io_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module gbc_io_subsystem (
   input  wire logic                    clock_main,
   input  wire logic                    synch_reset,
   input  wire gbc_io_pkg::io_bus_req_t bus,
   output logic [7:0]                   rdata,
   output logic                         rdata_valid,
   output logic                         timer_irq
);

   // Combinational replies of the two register blocks
   gbc_io_pkg::io_reply_t timer_reply;
   gbc_io_pkg::io_reply_t bank_reply;

   // ========================================================================
   // Register blocks
   // ========================================================================

   timer_unit u_timer (
      .clock_main  (clock_main),
      .synch_reset (synch_reset),
      .bus         (bus),
      .reply       (timer_reply),
      .timer_irq   (timer_irq)
   );

   // Serial, speed switch and colour-model registers
   misc_register_bank u_bank (
      .clock_main  (clock_main),
      .synch_reset (synch_reset),
      .bus         (bus),
      .reply       (bank_reply)
   );

   io_read_return u_read_return (
      .clock_main  (clock_main),
      .synch_reset (synch_reset),
      .bus         (bus),
      .timer_reply (timer_reply),
      .bank_reply  (bank_reply),
      .rdata       (rdata),
      .rdata_valid (rdata_valid)
   );

endmodule

`default_nettype wire

// ==== source/io_read_return.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gbc_io_settings.svh"

module io_read_return (
   input  wire logic                    clock_main,
   input  wire logic                    synch_reset,
   input  wire gbc_io_pkg::io_bus_req_t bus,
   input  wire gbc_io_pkg::io_reply_t   timer_reply,
   input  wire gbc_io_pkg::io_reply_t   bank_reply,
   output logic [7:0]                   rdata,
   output logic                         rdata_valid
);

   logic       read_req;
   logic [7:0] merged_data;

   assign read_req = (bus.re_l == gbc_io_pkg::strobe_active);

   // Unmapped addresses float to open bus
   always_comb begin
      if (timer_reply.hit) begin
         merged_data = timer_reply.data;
      end else if (bank_reply.hit) begin
         merged_data = bank_reply.data;
      end else begin
         merged_data = `GBC_IO_OPEN_BUS;
      end
   end

   // ========================================================================
   // Registered return
   // ========================================================================

   // Data holds its last value between reads
   always_ff @(posedge clock_main) begin
      if (read_req) begin
         rdata <= merged_data;
      end
   end

   always_ff @(posedge clock_main) begin
      if (synch_reset) begin
         rdata_valid <= 1'b0;
      end else begin
         rdata_valid <= read_req;
      end
   end

endmodule

`default_nettype wire

// ==== source/misc_register_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gbc_io_settings.svh"

module misc_register_bank (
   input  wire logic                    clock_main,
   input  wire logic                    synch_reset,
   input  wire gbc_io_pkg::io_bus_req_t bus,
   output gbc_io_pkg::io_reply_t        reply
);

   // ========================================================================
   // Register table
   // ========================================================================

   localparam int bank_size = 10;

   localparam logic [15:0] bank_addr [bank_size] = '{
      `GBC_IO_ADDR_SB,   `GBC_IO_ADDR_SC,   `GBC_IO_ADDR_KEY1, `GBC_IO_ADDR_FF6C,
      `GBC_IO_ADDR_FF72, `GBC_IO_ADDR_FF73, `GBC_IO_ADDR_FF74, `GBC_IO_ADDR_FF75,
      `GBC_IO_ADDR_FF76, `GBC_IO_ADDR_FF77
   };

   localparam logic [7:0] bank_reset [bank_size] = '{
      `GBC_IO_RST_SB,   `GBC_IO_RST_SC,   `GBC_IO_RST_KEY1, `GBC_IO_RST_FF6C,
      `GBC_IO_RST_FF7X, `GBC_IO_RST_FF7X, `GBC_IO_RST_FF7X, `GBC_IO_RST_FF75,
      `GBC_IO_RST_RO,   `GBC_IO_RST_RO
   };

   // Zero mask makes an entry read-only
   localparam logic [7:0] bank_mask [bank_size] = '{
      `GBC_IO_MASK_SB,   `GBC_IO_MASK_SC,   `GBC_IO_MASK_KEY1, `GBC_IO_MASK_FF6C,
      `GBC_IO_MASK_FF7X, `GBC_IO_MASK_FF7X, `GBC_IO_MASK_FF7X, `GBC_IO_MASK_FF75,
      `GBC_IO_MASK_RO,   `GBC_IO_MASK_RO
   };

   logic [7:0]           regs [bank_size];
   logic [bank_size-1:0] entry_sel;
   logic [7:0]           read_data;

   // Address match per entry, shared by write and read
   for (genvar g = 0; g < bank_size; g++) begin : g_sel
      assign entry_sel[g] = (bus.addr == bank_addr[g]);
   end

   // ========================================================================
   // Masked writes
   // ========================================================================

   always_ff @(posedge clock_main) begin
      if (synch_reset) begin
         for (int i = 0; i < bank_size; i++) begin
            regs[i] <= bank_reset[i];
         end
      end else if (bus.we_l == gbc_io_pkg::strobe_active) begin
         for (int i = 0; i < bank_size; i++) begin
            if (entry_sel[i]) begin
               regs[i] <= (regs[i] & ~bank_mask[i]) | (bus.wdata & bank_mask[i]);
            end
         end
      end
   end

   // Addresses are unique so at most one entry selects
   always_comb begin
      read_data = '0;
      for (int i = 0; i < bank_size; i++) begin
         if (entry_sel[i]) begin
            read_data = regs[i];
         end
      end
   end

   assign reply.hit  = (bus.re_l == gbc_io_pkg::strobe_active) && (|entry_sel);
   assign reply.data = read_data;

endmodule

`default_nettype wire

// ==== timer/timer_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gbc_io_settings.svh"

module timer_unit (
   input  wire logic                    clock_main,
   input  wire logic                    synch_reset,
   input  wire gbc_io_pkg::io_bus_req_t bus,
   output gbc_io_pkg::io_reply_t        reply,
   output logic                         timer_irq
);

   // ========================================================================
   // Register state
   // ========================================================================

   // Free-running divider, DIV is its upper byte
   logic [15:0] div_count;
   logic [7:0]  tima_q;
   logic [7:0]  tma_q;
   logic [7:0]  tac_q;

   logic        wr_div;
   logic        wr_tima;
   logic        wr_tma;
   logic        wr_tac;

   logic [15:0] period_mask;
   logic        tima_tick;
   logic        tima_overflow;

   // Write decode
   assign wr_div  = (bus.we_l == gbc_io_pkg::strobe_active) &&
                    (bus.addr == `GBC_IO_ADDR_DIV);
   assign wr_tima = (bus.we_l == gbc_io_pkg::strobe_active) &&
                    (bus.addr == `GBC_IO_ADDR_TIMA);
   assign wr_tma  = (bus.we_l == gbc_io_pkg::strobe_active) &&
                    (bus.addr == `GBC_IO_ADDR_TMA);
   assign wr_tac  = (bus.we_l == gbc_io_pkg::strobe_active) &&
                    (bus.addr == `GBC_IO_ADDR_TAC);

   // ========================================================================
   // Divider and tick generation
   // ========================================================================

   // Any write to DIV clears the whole divider
   always_ff @(posedge clock_main) begin
      if (synch_reset) begin
         div_count <= '0;
      end else if (wr_div) begin
         div_count <= '0;
      end else begin
         div_count <= div_count + 16'd1;
      end
   end

   // Low divider bits that wrap at the selected period
   always_comb begin
      case (tac_q[1:0])
         2'd0:    period_mask = 16'(`GBC_IO_TAC_PERIOD_0 - 1);
         2'd1:    period_mask = 16'(`GBC_IO_TAC_PERIOD_1 - 1);
         2'd2:    period_mask = 16'(`GBC_IO_TAC_PERIOD_2 - 1);
         default: period_mask = 16'(`GBC_IO_TAC_PERIOD_3 - 1);
      endcase
   end

   // Tick on the edge where the masked bits roll over to zero
   assign tima_tick = tac_q[2] && !wr_div &&
                      ((div_count & period_mask) == period_mask);

   // A CPU write to TIMA in the same cycle takes priority
   assign tima_overflow = tima_tick && (tima_q == 8'hFF) && !wr_tima;

   // ========================================================================
   // TIMA, TMA, TAC
   // ========================================================================

   always_ff @(posedge clock_main) begin
      if (synch_reset) begin
         tima_q <= '0;
      end else if (wr_tima) begin
         tima_q <= bus.wdata;
      end else if (tima_overflow) begin
         // Reload from TMA on the overflow edge
         tima_q <= tma_q;
      end else if (tima_tick) begin
         tima_q <= tima_q + 8'd1;
      end
   end

   always_ff @(posedge clock_main) begin
      if (synch_reset) begin
         tma_q <= '0;
         tac_q <= '0;
      end else begin
         if (wr_tma) begin
            tma_q <= bus.wdata;
         end
         // Upper TAC bits are stored and read back as written
         if (wr_tac) begin
            tac_q <= bus.wdata;
         end
      end
   end

   // One-cycle interrupt request per overflow
   always_ff @(posedge clock_main) begin
      if (synch_reset) begin
         timer_irq <= 1'b0;
      end else begin
         timer_irq <= tima_overflow;
      end
   end

   // ========================================================================
   // Read reply
   // ========================================================================

   always_comb begin
      reply.hit = (bus.re_l == gbc_io_pkg::strobe_active);
      case (bus.addr)
         `GBC_IO_ADDR_DIV:  reply.data = div_count[`GBC_IO_DIV_SHIFT +: 8];
         `GBC_IO_ADDR_TIMA: reply.data = tima_q;
         `GBC_IO_ADDR_TMA:  reply.data = tma_q;
         `GBC_IO_ADDR_TAC:  reply.data = tac_q;
         default: begin
            reply = gbc_io_pkg::reply_none;
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== common/gbc_io_pkg.sv ====
`default_nettype none

// ============================================================================
// Shared bus types for the I/O register page
// ============================================================================

package gbc_io_pkg;

   // One CPU access to the I/O page
   // Strobes are active low, like the original memory router bus
   typedef struct packed {
      logic [15:0] addr;
      logic [7:0]  wdata;
      logic        we_l;
      logic        re_l;
   } io_bus_req_t;

   // Combinational answer of one register block
   // hit only rises for a read to one of the block's own addresses
   typedef struct packed {
      logic       hit;
      logic [7:0] data;
   } io_reply_t;

   // Strobe polarity helpers
   localparam logic strobe_active = 1'b0;
   localparam logic strobe_idle   = 1'b1;

   // Request with both strobes idle
   localparam io_bus_req_t bus_idle = '{
      addr:  16'h0000,
      wdata: 8'h00,
      we_l:  strobe_idle,
      re_l:  strobe_idle
   };

   // Reply of a block that does not own the address
   localparam io_reply_t reply_none = '{hit: 1'b0, data: 8'h00};

endpackage

`default_nettype wire

// ==== common/gbc_io_settings.svh ====
`ifndef GBC_IO_SETTINGS_SVH
`define GBC_IO_SETTINGS_SVH

// ============================================================================
// Register addresses
// ============================================================================
`define GBC_IO_ADDR_DIV   16'hFF04
`define GBC_IO_ADDR_TIMA  16'hFF05
`define GBC_IO_ADDR_TMA   16'hFF06
`define GBC_IO_ADDR_TAC   16'hFF07

`define GBC_IO_ADDR_SB    16'hFF01
`define GBC_IO_ADDR_SC    16'hFF02
`define GBC_IO_ADDR_KEY1  16'hFF4D
// Undocumented colour-model registers
`define GBC_IO_ADDR_FF6C  16'hFF6C
`define GBC_IO_ADDR_FF72  16'hFF72
`define GBC_IO_ADDR_FF73  16'hFF73
`define GBC_IO_ADDR_FF74  16'hFF74
`define GBC_IO_ADDR_FF75  16'hFF75
`define GBC_IO_ADDR_FF76  16'hFF76
`define GBC_IO_ADDR_FF77  16'hFF77

// ============================================================================
// Bank reset values and write masks
// ============================================================================
`define GBC_IO_RST_SB     8'h00
`define GBC_IO_MASK_SB    8'hFF
`define GBC_IO_RST_SC     8'h7C
`define GBC_IO_MASK_SC    8'hFF
`define GBC_IO_RST_KEY1   8'hFD
`define GBC_IO_MASK_KEY1  8'h01
`define GBC_IO_RST_FF6C   8'hFE
`define GBC_IO_MASK_FF6C  8'h01
`define GBC_IO_RST_FF7X   8'h00
`define GBC_IO_MASK_FF7X  8'hFF
`define GBC_IO_RST_FF75   8'h8F
`define GBC_IO_MASK_FF75  8'h70
// FF76 and FF77 are read-only
`define GBC_IO_RST_RO     8'h00
`define GBC_IO_MASK_RO    8'h00

// TIMA tick periods in clocks, indexed by TAC[1:0]
`define GBC_IO_TAC_PERIOD_0  1024
`define GBC_IO_TAC_PERIOD_1  16
`define GBC_IO_TAC_PERIOD_2  64
`define GBC_IO_TAC_PERIOD_3  256

`define GBC_IO_OPEN_BUS   8'hFF
`define GBC_IO_DIV_SHIFT  8

`endif
